// File: rtl/cache_defs.svh
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// address and data widths
`define ADDR_W 16
`define WORD_W 32

// geometry
`define WORDS_PER_LINE 4
`define LINE_W 128
`define SETS 16
`define WAYS 2

// address split, tag | index | word | byte
`define INDEX_W 4
`define WORD_OFF_W 2
`define BYTE_OFF_W 2
`define TAG_W 8

// line view of the same address
`define LINE_NUM_W 12
`define LINE_OFF_W 4

`endif

// File: rtl/cacheAddrPkg.sv
`default_nettype none

`include "cache_defs.svh"

package cacheAddrPkg;

	// one byte address, read per field or per line
	typedef union packed {
		struct packed {
			logic [`TAG_W-1:0] tag;
			logic [`INDEX_W-1:0] index;
			logic [`WORD_OFF_W-1:0] wordOff;
			logic [`BYTE_OFF_W-1:0] byteOff;
		} fields;
		struct packed {
			logic [`LINE_NUM_W-1:0] lineNum; // memory line number
			logic [`LINE_OFF_W-1:0] lineOff;
		} line;
	} cacheAddr_u;

endpackage

`default_nettype wire

// File: rtl/cacheRequestLatch.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_defs.svh"

module cacheRequestLatch import cacheAddrPkg::*; (
	input logic clk,
	input logic reset,
	input logic reqValid,
	input logic reqWrite,
	input logic [`ADDR_W-1:0] reqAddr,
	input logic [`WORD_W-1:0] reqWdata,
	input logic rspValid,
	output logic reqReady,
	output logic pending,
	output logic curWrite,
	output cacheAddr_u curAddr,
	output logic [`WORD_W-1:0] curWdata
);

	logic accept;
	cacheAddr_u reqDecoded;

	assign reqReady = !pending; // one request in flight
	assign accept = reqValid && reqReady;

	// word accesses only, byte offset dropped
	always_comb begin
		reqDecoded = reqAddr;
		reqDecoded.fields.byteOff = '0;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pending <= 1'b0;
		end else if (accept) begin
			pending <= 1'b1;
		end else if (rspValid) begin
			pending <= 1'b0; // released as the response leaves
		end
	end

	// held stable for the whole miss sequence
	always_ff @(posedge clk) begin
		if (accept) begin
			curWrite <= reqWrite;
			curAddr <= reqDecoded;
			curWdata <= reqWdata;
		end
	end

endmodule

`default_nettype wire

// File: rtl/cacheWay.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_defs.svh"

module cacheWay import cacheAddrPkg::*; (
	input logic clk,
	input logic reset,
	input cacheAddr_u curAddr,
	input logic [`WORD_W-1:0] curWdata,
	input logic wordWrite,
	input logic lineFill,
	input logic makeClean,
	input logic [`LINE_W-1:0] fillLine,
	output logic hit,
	output logic valid,
	output logic dirty,
	output logic [`TAG_W-1:0] wayTag,
	output logic [`LINE_W-1:0] wayLine
);

	logic [`TAG_W-1:0] tagMem [`SETS];
	logic [`LINE_W-1:0] dataMem [`SETS];
	logic [`SETS-1:0] validBits;
	logic [`SETS-1:0] dirtyBits;
	logic [`INDEX_W-1:0] index;

	// --------------------------------------------------
	// lookup at the held index

	assign index = curAddr.fields.index;
	assign valid = validBits[index];
	assign dirty = dirtyBits[index];
	assign wayTag = tagMem[index];
	assign wayLine = dataMem[index];
	assign hit = valid && (wayTag == curAddr.fields.tag);

	// --------------------------------------------------
	// line state

	always_ff @(posedge clk) begin
		if (reset) begin
			validBits <= '0;
			dirtyBits <= '0;
		end else begin
			if (lineFill) begin
				validBits[index] <= 1'b1;
				dirtyBits[index] <= 1'b0; // fresh from memory
			end else if (wordWrite) begin
				dirtyBits[index] <= 1'b1;
			end else if (makeClean) begin
				dirtyBits[index] <= 1'b0; // victim written back
			end
		end
	end

	// --------------------------------------------------
	// tags and data

	always_ff @(posedge clk) begin
		if (lineFill) begin
			tagMem[index] <= curAddr.fields.tag;
			dataMem[index] <= fillLine;
		end else if (wordWrite) begin
			dataMem[index][curAddr.fields.wordOff*`WORD_W +: `WORD_W] <= curWdata;
		end
	end

	// the controller never fills and writes one way in the same cycle
	strobeExclusive: assert property (
		@(posedge clk) disable iff (reset)
		!(wordWrite && lineFill)
	) else $error("cacheWay: wordWrite and lineFill together");

	// a store only lands on a line that holds the requested address
	writeOnHit: assert property (
		@(posedge clk) disable iff (reset)
		wordWrite |-> hit
	) else $error("cacheWay: wordWrite without a hit");

	// cleaning is only asked for a dirty resident line
	cleanOnDirty: assert property (
		@(posedge clk) disable iff (reset)
		makeClean |-> (valid && dirty)
	) else $error("cacheWay: makeClean on a clean or invalid line");

endmodule

`default_nettype wire

// File: rtl/cacheController.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_defs.svh"

module cacheController import cacheAddrPkg::*; (
	input logic clk,
	input logic reset,
	input logic pending,
	input logic curWrite,
	input cacheAddr_u curAddr,
	input logic [`WAYS-1:0] hit,
	input logic [`WAYS-1:0] valid,
	input logic [`WAYS-1:0] dirty,
	input logic [`TAG_W-1:0] wayTag [`WAYS],
	input logic [`LINE_W-1:0] wayLine [`WAYS],
	input logic [`LINE_W-1:0] fillLine,
	input logic fillDone,
	input logic wbDone,
	output logic [`WAYS-1:0] wordWrite,
	output logic [`WAYS-1:0] lineFill,
	output logic [`WAYS-1:0] makeClean,
	output logic rspValid,
	output logic [`WORD_W-1:0] rspRdata,
	output logic rspHit,
	output logic fillReq,
	output logic [`ADDR_W-1:0] fillAddr,
	output logic wbReq,
	output logic [`ADDR_W-1:0] wbAddr,
	output logic [`LINE_W-1:0] wbLine
);

	localparam logic [1:0] stateLookup = 2'd0;
	localparam logic [1:0] stateWriteBack = 2'd1;
	localparam logic [1:0] stateFill = 2'd2;
	localparam logic [1:0] stateRespond = 2'd3;

	logic [1:0] state;
	logic [1:0] nextState;
	logic [`SETS-1:0] lruBits; // per set, the least recent way
	logic missed;
	logic victim;
	logic victimPick;
	logic hitWay;
	logic anyHit;
	logic [`INDEX_W-1:0] index;
	logic [`WORD_W-1:0] hitWord;
	logic [`WORD_W-1:0] rdataQ;
	cacheAddr_u victimAddr;

	assign index = curAddr.fields.index;
	assign anyHit = |hit;
	assign hitWay = hit[1]; // at most one way hits
	assign hitWord = wayLine[hitWay][curAddr.fields.wordOff*`WORD_W +: `WORD_W];

	// --------------------------------------------------
	// victim selection and memory addresses

	// empty way first, way 0 before way 1
	always_comb begin
		if (!valid[0]) begin
			victimPick = 1'b0;
		end else if (!valid[1]) begin
			victimPick = 1'b1;
		end else begin
			victimPick = lruBits[index];
		end
	end

	// victim address = its own tag at the current index
	always_comb begin
		victimAddr = curAddr;
		victimAddr.fields.tag = wayTag[victim];
	end

	assign fillAddr = {curAddr.line.lineNum, {`LINE_OFF_W{1'b0}}};
	assign wbAddr = {victimAddr.line.lineNum, {`LINE_OFF_W{1'b0}}};
	assign wbLine = wayLine[victim]; // index is held, line stays put

	assign fillReq = (state == stateFill);
	assign wbReq = (state == stateWriteBack);
	assign rspValid = (state == stateRespond);
	assign rspHit = !missed;
	assign rspRdata = rdataQ;

	// --------------------------------------------------
	// way strobes

	always_comb begin
		wordWrite = '0;
		lineFill = '0;
		makeClean = '0;
		case (state)
			stateLookup: begin
				if (pending && anyHit && curWrite) begin
					wordWrite[hitWay] = 1'b1;
				end
			end
			stateWriteBack: begin
				if (wbDone) begin
					makeClean[victim] = 1'b1;
				end
			end
			stateFill: begin
				if (fillDone) begin
					lineFill[victim] = 1'b1;
				end
			end
			default: begin
			end
		endcase
	end

	// --------------------------------------------------
	// FSM

	always_comb begin
		nextState = state;
		case (state)
			stateLookup: begin
				if (pending) begin
					if (anyHit) begin
						nextState = stateRespond;
					end else if (valid[victimPick] && dirty[victimPick]) begin
						nextState = stateWriteBack; // flush before replacing
					end else begin
						nextState = stateFill;
					end
				end
			end
			stateWriteBack: begin
				if (wbDone) begin
					nextState = stateFill;
				end
			end
			stateFill: begin
				if (fillDone) begin
					nextState = stateLookup; // look again, now hits
				end
			end
			default: begin
				nextState = stateLookup;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= stateLookup;
			lruBits <= '0;
			missed <= 1'b0;
			victim <= 1'b0;
		end else begin
			state <= nextState;
			if (state == stateLookup && pending) begin
				if (anyHit) begin
					lruBits[index] <= !hitWay; // other way becomes least recent
				end else begin
					missed <= 1'b1;
					victim <= victimPick;
				end
			end
			if (state == stateRespond) begin
				missed <= 1'b0;
			end
		end
	end

	// read word, zero for stores
	always_ff @(posedge clk) begin
		if (state == stateLookup && pending && anyHit) begin
			rdataQ <= curWrite ? '0 : hitWord;
		end
	end

	// --------------------------------------------------
	// checks

	memReqExclusive: assert property (
		@(posedge clk) disable iff (reset)
		!(fillReq && wbReq)
	) else $error("cacheController: fillReq and wbReq together");

	singleHit: assert property (
		@(posedge clk) disable iff (reset)
		$onehot0(hit)
	) else $error("cacheController: more than one way hits");

	// memory must hand over a defined line with its done pulse
	fillLineKnown: assert property (
		@(posedge clk) disable iff (reset)
		(fillReq && fillDone) |-> !$isunknown(fillLine)
	) else $error("cacheController: fillLine unknown at fillDone");

endmodule

`default_nettype wire

// File: rtl/cacheTop.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_defs.svh"

module cacheTop import cacheAddrPkg::*; (
	input logic clk,
	input logic reset,
	input logic reqValid,
	input logic reqWrite,
	input logic [`ADDR_W-1:0] reqAddr,
	input logic [`WORD_W-1:0] reqWdata,
	output logic reqReady,
	output logic rspValid,
	output logic [`WORD_W-1:0] rspRdata,
	output logic rspHit,
	output logic fillReq,
	output logic [`ADDR_W-1:0] fillAddr,
	input logic fillDone,
	input logic [`LINE_W-1:0] fillLine,
	output logic wbReq,
	output logic [`ADDR_W-1:0] wbAddr,
	output logic [`LINE_W-1:0] wbLine,
	input logic wbDone
);

	logic pending;
	logic curWrite;
	cacheAddr_u curAddr;
	logic [`WORD_W-1:0] curWdata;
	logic [`WAYS-1:0] hit;
	logic [`WAYS-1:0] valid;
	logic [`WAYS-1:0] dirty;
	logic [`WAYS-1:0] wordWrite;
	logic [`WAYS-1:0] lineFill;
	logic [`WAYS-1:0] makeClean;
	logic [`TAG_W-1:0] wayTag [`WAYS];
	logic [`LINE_W-1:0] wayLine [`WAYS];

	cacheRequestLatch latch (
		.clk(clk), .reset(reset),
		.reqValid(reqValid), .reqWrite(reqWrite), .reqAddr(reqAddr), .reqWdata(reqWdata),
		.rspValid(rspValid),
		.reqReady(reqReady), .pending(pending), .curWrite(curWrite),
		.curAddr(curAddr), .curWdata(curWdata)
	);

	for (genvar g = 0; g < `WAYS; g++) begin : gWay
		cacheWay way (
			.clk(clk), .reset(reset),
			.curAddr(curAddr), .curWdata(curWdata),
			.wordWrite(wordWrite[g]), .lineFill(lineFill[g]), .makeClean(makeClean[g]),
			.fillLine(fillLine),
			.hit(hit[g]), .valid(valid[g]), .dirty(dirty[g]),
			.wayTag(wayTag[g]), .wayLine(wayLine[g])
		);
	end

	cacheController ctrl (
		.clk(clk), .reset(reset),
		.pending(pending), .curWrite(curWrite), .curAddr(curAddr),
		.hit(hit), .valid(valid), .dirty(dirty), .wayTag(wayTag), .wayLine(wayLine),
		.fillLine(fillLine), .fillDone(fillDone), .wbDone(wbDone),
		.wordWrite(wordWrite), .lineFill(lineFill), .makeClean(makeClean),
		.rspValid(rspValid), .rspRdata(rspRdata), .rspHit(rspHit),
		.fillReq(fillReq), .fillAddr(fillAddr),
		.wbReq(wbReq), .wbAddr(wbAddr), .wbLine(wbLine)
	);

endmodule

`default_nettype wire

// File: dv/memoryModel.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_defs.svh"

module memoryModel (
	input logic clk,
	input logic fillReq,
	input logic [`ADDR_W-1:0] fillAddr,
	output logic fillDone,
	output logic [`LINE_W-1:0] fillLine,
	input logic wbReq,
	input logic [`ADDR_W-1:0] wbAddr,
	input logic [`LINE_W-1:0] wbLine,
	output logic wbDone,
	output logic [31:0] wbCount
);

	localparam int wordAddrW = `ADDR_W - `BYTE_OFF_W;
	localparam int memWords = 1 << wordAddrW;

	logic [`WORD_W-1:0] mem [memWords];

	// done pulse 1 to 6 cycles after the request is seen
	task automatic waitRandom();
		int unsigned delay;
		delay = ($urandom % 6) + 1;
		repeat (delay) @(posedge clk);
		#2;
	endtask

	task automatic serveFill();
		logic [wordAddrW-1:0] base;
		base = fillAddr[`ADDR_W-1:`BYTE_OFF_W];
		for (int w = 0; w < `WORDS_PER_LINE; w++) begin
			fillLine[w*`WORD_W +: `WORD_W] = mem[base + w]; // word 0 in the low bits
		end
		fillDone = 1'b1;
	endtask

	task automatic serveWriteBack();
		logic [wordAddrW-1:0] base;
		base = wbAddr[`ADDR_W-1:`BYTE_OFF_W];
		for (int w = 0; w < `WORDS_PER_LINE; w++) begin
			mem[base + w] = wbLine[w*`WORD_W +: `WORD_W];
		end
		wbCount = wbCount + 1;
		wbDone = 1'b1;
	endtask

	initial begin
		void'($urandom(40028));
		for (int i = 0; i < memWords; i++) begin
			mem[i] = i ^ 32'h5A5A0000; // own word address xor pattern
		end
		fillDone = 1'b0;
		wbDone = 1'b0;
		fillLine = '0;
		wbCount = 0;
		forever begin
			@(posedge clk);
			#2;
			fillDone = 1'b0;
			wbDone = 1'b0;
			if (fillReq === 1'b1) begin
				waitRandom();
				serveFill();
			end else if (wbReq === 1'b1) begin
				waitRandom();
				serveWriteBack();
			end
		end
	end

endmodule

`default_nettype wire

// File: dv/cacheTb.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_defs.svh"

module cacheTb;

	localparam int numRows = 22;
	localparam int cycleLimit = numRows * 40;

	logic clk;
	logic reset;
	logic reqValid;
	logic reqWrite;
	logic [`ADDR_W-1:0] reqAddr;
	logic [`WORD_W-1:0] reqWdata;
	logic reqReady;
	logic rspValid;
	logic [`WORD_W-1:0] rspRdata;
	logic rspHit;
	logic fillReq;
	logic [`ADDR_W-1:0] fillAddr;
	logic fillDone;
	logic [`LINE_W-1:0] fillLine;
	logic wbReq;
	logic [`ADDR_W-1:0] wbAddr;
	logic [`LINE_W-1:0] wbLine;
	logic wbDone;
	logic [31:0] wbCount;

	// stimulus table
	logic rowWrite [numRows];
	logic [`ADDR_W-1:0] rowAddr [numRows];
	logic [`WORD_W-1:0] rowWdata [numRows];
	logic [`WORD_W-1:0] rowRdata [numRows];
	logic rowHit [numRows];
	logic [31:0] rowWbCount [numRows];
	int rowCount;

	int rdataErrors;
	int hitErrors;
	int wbErrors;
	int latencyErrors;
	int handshakeErrors;
	int cycleCount;

	cacheTop DUT (
		.clk(clk), .reset(reset),
		.reqValid(reqValid), .reqWrite(reqWrite), .reqAddr(reqAddr), .reqWdata(reqWdata),
		.reqReady(reqReady), .rspValid(rspValid), .rspRdata(rspRdata), .rspHit(rspHit),
		.fillReq(fillReq), .fillAddr(fillAddr), .fillDone(fillDone), .fillLine(fillLine),
		.wbReq(wbReq), .wbAddr(wbAddr), .wbLine(wbLine), .wbDone(wbDone)
	);

	memoryModel memory (
		.clk(clk),
		.fillReq(fillReq), .fillAddr(fillAddr), .fillDone(fillDone), .fillLine(fillLine),
		.wbReq(wbReq), .wbAddr(wbAddr), .wbLine(wbLine), .wbDone(wbDone),
		.wbCount(wbCount)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// word that memory holds before any write-back
	function automatic logic [`WORD_W-1:0] initialWord(input logic [`ADDR_W-1:0] addr);
		logic [`WORD_W-1:0] wordAddr;
		wordAddr = '0;
		wordAddr[`ADDR_W-`BYTE_OFF_W-1:0] = addr[`ADDR_W-1:`BYTE_OFF_W];
		return wordAddr ^ 32'h5A5A0000;
	endfunction

	task automatic addRow(input logic write, input logic [`ADDR_W-1:0] addr,
			input logic [`WORD_W-1:0] wdata, input logic [`WORD_W-1:0] rdata,
			input logic expHit, input logic [31:0] expWb);
		rowWrite[rowCount] = write;
		rowAddr[rowCount] = addr;
		rowWdata[rowCount] = wdata;
		rowRdata[rowCount] = rdata;
		rowHit[rowCount] = expHit;
		rowWbCount[rowCount] = expWb;
		rowCount++;
	endtask

	task automatic loadTable();
		// read miss, then a hit in the same line
		addRow(1'b0, 16'h0010, 32'h0, initialWord(16'h0010), 1'b0, 32'd0);
		addRow(1'b0, 16'h0014, 32'h0, initialWord(16'h0014), 1'b1, 32'd0);
		// write hit, neighbours untouched
		addRow(1'b1, 16'h0018, 32'hDEADBEEF, 32'h0, 1'b1, 32'd0);
		addRow(1'b0, 16'h0018, 32'h0, 32'hDEADBEEF, 1'b1, 32'd0);
		addRow(1'b0, 16'h001C, 32'h0, initialWord(16'h001C), 1'b1, 32'd0);
		addRow(1'b0, 16'h0010, 32'h0, initialWord(16'h0010), 1'b1, 32'd0);
		// write miss allocates
		addRow(1'b1, 16'h0124, 32'h12345678, 32'h0, 1'b0, 32'd0);
		addRow(1'b0, 16'h0124, 32'h0, 32'h12345678, 1'b1, 32'd0);
		addRow(1'b0, 16'h0120, 32'h0, initialWord(16'h0120), 1'b1, 32'd0);
		// set 3: A, B, touch A, C replaces B
		addRow(1'b0, 16'h0030, 32'h0, initialWord(16'h0030), 1'b0, 32'd0);
		addRow(1'b0, 16'h0130, 32'h0, initialWord(16'h0130), 1'b0, 32'd0);
		addRow(1'b0, 16'h0034, 32'h0, initialWord(16'h0034), 1'b1, 32'd0);
		addRow(1'b0, 16'h0230, 32'h0, initialWord(16'h0230), 1'b0, 32'd0);
		addRow(1'b0, 16'h0030, 32'h0, initialWord(16'h0030), 1'b1, 32'd0);
		addRow(1'b0, 16'h0130, 32'h0, initialWord(16'h0130), 1'b0, 32'd0);
		// set 1: dirty line out, then back from memory
		addRow(1'b0, 16'h0110, 32'h0, initialWord(16'h0110), 1'b0, 32'd0);
		addRow(1'b0, 16'h0210, 32'h0, initialWord(16'h0210), 1'b0, 32'd1);
		addRow(1'b0, 16'h0018, 32'h0, 32'hDEADBEEF, 1'b0, 32'd1); // clean victim
		// set 2: write miss evicts a dirty line
		addRow(1'b0, 16'h0220, 32'h0, initialWord(16'h0220), 1'b0, 32'd1);
		addRow(1'b1, 16'h0320, 32'hCAFEF00D, 32'h0, 1'b0, 32'd2);
		addRow(1'b0, 16'h0124, 32'h0, 32'h12345678, 1'b0, 32'd2);
		addRow(1'b0, 16'h0320, 32'h0, 32'hCAFEF00D, 1'b1, 32'd2);
	endtask

	// reqReady low while a request is held, high once it is released
	task automatic expectReady(input int row, input logic expReady);
		assert (reqReady === expReady) else begin
			$display("[ERROR] row %0d reqReady expected 0x%0h got 0x%0h",
				row, expReady, reqReady);
			handshakeErrors++;
		end
	endtask

	// --------------------------------------------------
	// one table row: request, response, checks

	task automatic runRow(input int row);
		int latency;
		latency = 0;
		while (reqReady !== 1'b1) begin
			@(posedge clk);
			#2;
		end
		reqValid = 1'b1;
		reqWrite = rowWrite[row];
		reqAddr = rowAddr[row];
		reqWdata = rowWdata[row];
		@(posedge clk); // accepting edge
		#2;
		reqValid = 1'b0;
		while (rspValid !== 1'b1) begin
			expectReady(row, 1'b0);
			@(posedge clk);
			#2;
			latency++;
		end
		expectReady(row, 1'b0);
		assert (rspRdata === rowRdata[row]) else begin
			$display("[ERROR] row %0d rspRdata expected 0x%08h got 0x%08h",
				row, rowRdata[row], rspRdata);
			rdataErrors++;
		end
		assert (rspHit === rowHit[row]) else begin
			$display("[ERROR] row %0d rspHit expected 0x%0h got 0x%0h",
				row, rowHit[row], rspHit);
			hitErrors++;
		end
		assert (wbCount === rowWbCount[row]) else begin
			$display("[ERROR] row %0d wbCount expected 0x%0h got 0x%0h",
				row, rowWbCount[row], wbCount);
			wbErrors++;
		end
		if (rowHit[row]) begin
			assert (latency == 1) else begin
				$display("[ERROR] row %0d rspValid latency expected 0x1 got 0x%0h",
					row, latency);
				latencyErrors++;
			end
		end
		@(posedge clk); // end of the response cycle
		#2;
		expectReady(row, 1'b1);
		assert (rspValid === 1'b0) else begin
			$display("[ERROR] row %0d rspValid expected 0x0 got 0x%0h", row, rspValid);
			handshakeErrors++;
		end
	endtask

	// --------------------------------------------------
	// main sequence

	initial begin
		reset = 1'b1;
		reqValid = 1'b0;
		reqWrite = 1'b0;
		reqAddr = '0;
		reqWdata = '0;
		rdataErrors = 0;
		hitErrors = 0;
		wbErrors = 0;
		latencyErrors = 0;
		handshakeErrors = 0;
		rowCount = 0;
		loadTable();
		repeat (4) @(posedge clk);
		#2;
		reset = 1'b0;
		for (int row = 0; row < rowCount; row++) begin
			runRow(row);
		end
		$display("errors: rspRdata %0d, rspHit %0d, wbCount %0d, latency %0d, handshake %0d",
			rdataErrors, hitErrors, wbErrors, latencyErrors, handshakeErrors);
		if (rdataErrors + hitErrors + wbErrors + latencyErrors + handshakeErrors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	// watchdog
	initial begin
		cycleCount = 0;
		while (cycleCount < cycleLimit) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("timeout: the table did not complete within %0d cycles", cycleLimit);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
+incdir+rtl
rtl/cacheAddrPkg.sv
rtl/cacheRequestLatch.sv
rtl/cacheWay.sv
rtl/cacheController.sv
rtl/cacheTop.sv
dv/memoryModel.sv
dv/cacheTb.sv
